//--- build.f
rtl/zx_port_pkg.sv
rtl/zx_cfg_pkg.sv
rtl/z80_io_strobe.sv
rtl/port_decoder.sv
rtl/mem_pager.sv
rtl/ext_config.sv
rtl/port_read_mux.sv
rtl/zx_ports.sv
dv/tb_zx_ports.sv

//--- Makefile
# Verilator build and run for the I/O port block

VERILATOR ?= verilator
TOP       ?= tb_zx_ports
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_zx_ports.sv
// testbench for the I/O port block, xorshift stimulus,
// reference model of the port rules, compare tasks and timeout

`timescale 1ns/1ps

module tb_zx_ports
	import zx_port_pkg::*;
	import zx_cfg_pkg::*;
();

	localparam int N_ACCESS       = 400;
	localparam int TIMEOUT_CYCLES = N_ACCESS * 4 + 50;

	logic        zclk, rst_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n, rd_n, wr_n, dos;
	logic [4:0]  keys;
	logic        tape_in;
	logic [4:0]  kjoy;
	logic [7:0]  mouse;
	logic [1:0]  rom_sel;
	logic [7:0]  dout, border, p7ffd, peff7;
	logic        dataout, porthit;
	logic [5:0]  pent1m_page;
	logic        pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	logic        shadow_en, rom_we, font_we, set_nmi, clr_nmi;
	logic [7:0]  romconfig, vpage, page00, page01, page10, page11, vconfig, cpuconfig;

	// reference model state
	logic [7:0] m_7ffd, m_eff7, m_border;
	logic       m_rom;
	logic [3:0] m_ctrl; // nmi, fntw, romrw, shadow
	logic [7:0] m_ext [0:255];

	logic [31:0] rng;
	int          errors, checks, cycles;

	zx_ports u_dut (.*);

	initial
	begin
		zclk = 1'b0;
		forever #50 zclk = ~zclk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] pick_port(input logic [31:0] r);
		case (r % 32'd9)
			32'd0:   return 8'hFE;
			32'd1:   return 8'hF6;
			32'd2:   return 8'hFD;
			32'd3:   return 8'hF7;
			32'd4:   return 8'hBF;
			32'd5:   return 8'hBE;
			32'd6:   return 8'h1F;
			32'd7:   return 8'hDF;
			default: return 8'h7F; // unmapped
		endcase
	endfunction

	function automatic logic [7:0] pick_ext(input logic [31:0] r);
		case (r % 32'd9)
			32'd0:   return 8'h00;
			32'd1:   return 8'h02;
			32'd2:   return 8'h03;
			32'd3:   return 8'h04;
			32'd4:   return 8'h05;
			32'd5:   return 8'h06;
			32'd6:   return 8'h07;
			32'd7:   return 8'h08;
			default: return 8'h10;
		endcase
	endfunction

	function automatic logic is_ext(input logic [7:0] hi);
		case (hi)
			ROMCONFIG, VPAGE, PAGE00, PAGE01, PAGE10, PAGE11, VCONFIG, CPUCONFIG:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// expected values from the port rules
	function automatic port_sel_e expect_sel(input logic [15:0] addr, input logic shd);
		logic [7:0] lo;
		lo = addr[7:0];
		if (lo == 8'hFE || lo == 8'hF6)
			return SEL_FE;
		if (lo == 8'hFD && !addr[15])
			return SEL_7FFD;
		if (lo == 8'hF7 && addr[8] && !addr[12] && !shd)
			return SEL_EFF7;
		if (lo == 8'hBF)
			return SEL_BF;
		if (lo == 8'hBE)
			return SEL_BE;
		if (lo == 8'h1F && !shd)
			return SEL_KJOY;
		if (lo == 8'hDF)
			return SEL_MOUSE;
		return SEL_NONE;
	endfunction

	function automatic logic [7:0] expect_read(input port_sel_e s, input logic [15:0] addr);
		case (s)
			SEL_FE:    return {1'b1, tape_in, 1'b0, keys};
			SEL_KJOY:  return {3'b000, kjoy};
			SEL_MOUSE: return mouse;
			SEL_BF:    return {4'b0000, m_ctrl};
			SEL_BE:
				if (addr[11:8] == 4'hA)
					return m_7ffd;
				else if (addr[11:8] == 4'hB)
					return m_eff7;
				else
					return 8'hFF;
			default:   return 8'hFF;
		endcase
	endfunction

	function automatic logic [7:0] expect_p7ffd();
		return {(m_eff7[2] ? 3'b000 : m_7ffd[7:5]), m_rom, m_7ffd[3:0]};
	endfunction

	function automatic logic [7:0] expect_peff7();
		if (m_eff7[2])
			return {m_eff7[7], 1'b0, m_eff7[5:4], 3'b000, m_eff7[0]};
		return m_eff7;
	endfunction

	task automatic apply_write(input port_sel_e s, input logic [7:0] hi, input logic [7:0] d);
		case (s)
			SEL_FE:   m_border = {d[1], 1'b0, d[2], 1'b0, d[0], 3'b000};
			SEL_7FFD:
				if (!(m_7ffd[5] && m_eff7[2])) // locked in 48k mode
				begin
					m_7ffd = d;
					m_rom  = d[4];
				end
			SEL_EFF7: m_eff7 = d;
			SEL_BF:
			begin
				m_ctrl = d[3:0];
				if (hi == 8'h00)
					m_border = d;
				else if (is_ext(hi))
					m_ext[hi] = d;
			end
			default:  ;
		endcase
	endtask

	//////////////////////////////////////////////////
	// compare tasks
	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_sel(input string name, input port_sel_e got, input port_sel_e exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t %s got %s expected %s", $time, name, got.name(), exp.name());
		end
	endtask

	task automatic check_state();
		check_byte("border", border, m_border);
		check_byte("p7ffd", p7ffd, expect_p7ffd());
		check_byte("peff7", peff7, expect_peff7());
		check_byte("pent1m_page", {2'b00, pent1m_page}, {2'b00, m_7ffd[7:5], m_7ffd[2:0]});
		check_bit("pent1m_rom", pent1m_rom, m_7ffd[4]);
		check_bit("pent1m_1m_on", pent1m_1m_on, ~m_eff7[2]);
		check_bit("pent1m_ram0_0", pent1m_ram0_0, m_eff7[3]);
		check_bit("shadow_en", shadow_en, m_ctrl[CFG_SHADOW_BIT]);
		check_bit("rom_we", rom_we, m_ctrl[CFG_ROMRW_BIT]);
		check_bit("font_we", font_we, m_ctrl[CFG_FNTW_BIT]);
		check_bit("set_nmi", set_nmi, m_ctrl[CFG_NMI_BIT]);
		check_bit("clr_nmi", clr_nmi, 1'b0);
		check_byte("romconfig", romconfig, m_ext[ROMCONFIG]);
		check_byte("vpage", vpage, m_ext[VPAGE]);
		check_byte("page00", page00, m_ext[PAGE00]);
		check_byte("page01", page01, m_ext[PAGE01]);
		check_byte("page10", page10, m_ext[PAGE10]);
		check_byte("page11", page11, m_ext[PAGE11]);
		check_byte("vconfig", vconfig, m_ext[VCONFIG]);
		check_byte("cpuconfig", cpuconfig, m_ext[CPUCONFIG]);
	endtask

	// one Z80 bus cycle, 3 clocks active then 1 idle
	task automatic run_access();
		logic [31:0] r1, r2, r3;
		logic [7:0]  lo, hi, d, rd_exp;
		logic        wr;
		port_sel_e   s;
		int          nmi_cnt;
		rng = xorshift(rng);
		r1  = rng;
		rng = xorshift(rng);
		r2  = rng;
		rng = xorshift(rng);
		r3  = rng;
		lo  = pick_port(r1);
		hi  = r2[15:8];
		if (lo == 8'hBF && r2[0])
			hi = pick_ext(r1 >> 8);
		else if (lo == 8'hBE && r2[0])
			hi = {r2[15:12], (r2[1] ? 4'hB : 4'hA)};
		else if (lo == 8'hF7 && r2[0])
			hi = 8'hEF;
		d  = r2[23:16];
		wr = r2[24];

		@(negedge zclk);
		a       = {hi, lo};
		din     = d;
		dos     = (r2[26:25] == 2'b00);
		keys    = r3[4:0];
		tape_in = r3[5];
		kjoy    = r3[10:6];
		mouse   = r3[18:11];
		iorq_n  = 1'b0;
		wr_n    = ~wr;
		rd_n    = wr;
		s       = expect_sel({hi, lo}, dos | m_ctrl[CFG_SHADOW_BIT]);
		rd_exp  = expect_read(s, {hi, lo});
		nmi_cnt = 0;
		for (int i = 0; i < 3; i++)
		begin
			@(negedge zclk);
			if (clr_nmi)
				nmi_cnt++;
			if (i == 0)
			begin
				check_sel("port_sel", u_dut.port_sel, s);
				check_bit("porthit", porthit, s != SEL_NONE);
				check_bit("dataout", dataout, !wr && (s != SEL_NONE));
				if (!wr)
					check_byte("dout", dout, rd_exp);
			end
		end
		iorq_n = 1'b1; // idle cycle follows
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		if (wr)
			apply_write(s, hi, d);
		if (nmi_cnt != ((wr && s == SEL_BE) ? 1 : 0))
		begin
			errors++;
			$display("clr_nmi was high in %0d cycles of a bus cycle to port %04h", nmi_cnt, a);
		end
		check_state();
	endtask

	//////////////////////////////////////////////////
	// timeout watchdog
	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge zclk);
			cycles++;
		end
		$display("run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		errors  = 0;
		checks  = 0;
		rng     = 32'd39;
		rng     = xorshift(rng);
		rom_sel = rng[1:0]; // fixed boot rom choice
		rst_n   = 1'b0;
		a       = 16'h0000;
		din     = 8'h00;
		iorq_n  = 1'b1;
		rd_n    = 1'b1;
		wr_n    = 1'b1;
		dos     = 1'b0;
		keys    = 5'h00;
		tape_in = 1'b0;
		kjoy    = 5'h00;
		mouse   = 8'h00;

		m_7ffd   = 8'h00;
		m_eff7   = 8'h00;
		m_border = 8'h00;
		m_rom    = rom_sel[0];
		m_ctrl   = 4'h0;
		m_ext    = '{default: EXT_RESET};

		repeat (3) @(negedge zclk);
		rst_n = 1'b1;
		repeat (2) @(negedge zclk); // rom bit sync settles
		check_state();

		for (int n = 0; n < N_ACCESS; n++)
			run_access();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- rtl/zx_ports.sv
// I/O port block top, strobes, decode, paging,
// config registers and read mux

`timescale 1ns/1ps

module zx_ports
	import zx_port_pkg::*;
(
	input  logic        zclk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        dos,
	input  logic [4:0]  keys,
	input  logic        tape_in,
	input  logic [4:0]  kjoy,
	input  logic [7:0]  mouse,
	input  logic [1:0]  rom_sel,
	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit,
	output logic [7:0]  border,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic [5:0]  pent1m_page,
	output logic        pent1m_rom,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0,
	output logic        shadow_en,
	output logic        rom_we,
	output logic        font_we,
	output logic        set_nmi,
	output logic        clr_nmi,
	output logic [7:0]  romconfig,
	output logic [7:0]  vpage,
	output logic [7:0]  page00,
	output logic [7:0]  page01,
	output logic [7:0]  page10,
	output logic [7:0]  page11,
	output logic [7:0]  vconfig,
	output logic [7:0]  cpuconfig
);

	logic       port_wr, port_rd;
	logic       shadow;
	port_sel_e  port_sel;
	logic [7:0] p7ffd_raw, peff7_raw;

	z80_io_strobe u_strobe (
		.zclk    (zclk),
		.rst_n   (rst_n),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.port_wr (port_wr),
		.port_rd (port_rd)
	);

	port_decoder u_decode (
		.a        (a),
		.shadow   (shadow),
		.port_sel (port_sel),
		.porthit  (porthit)
	);

	mem_pager u_pager (
		.zclk          (zclk),
		.rst_n         (rst_n),
		.port_wr       (port_wr),
		.port_sel      (port_sel),
		.din           (din),
		.rom_sel       (rom_sel),
		.p7ffd         (p7ffd),
		.peff7         (peff7),
		.p7ffd_raw     (p7ffd_raw),
		.peff7_raw     (peff7_raw),
		.pent1m_page   (pent1m_page),
		.pent1m_rom    (pent1m_rom),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0)
	);

	ext_config u_cfg (
		.zclk      (zclk),
		.rst_n     (rst_n),
		.port_wr   (port_wr),
		.port_sel  (port_sel),
		.a_hi      (a[15:8]),
		.din       (din),
		.dos       (dos),
		.shadow    (shadow),
		.shadow_en (shadow_en),
		.rom_we    (rom_we),
		.font_we   (font_we),
		.set_nmi   (set_nmi),
		.clr_nmi   (clr_nmi),
		.border    (border),
		.romconfig (romconfig),
		.vpage     (vpage),
		.page00    (page00),
		.page01    (page01),
		.page10    (page10),
		.page11    (page11),
		.vconfig   (vconfig),
		.cpuconfig (cpuconfig)
	);

	port_read_mux u_rdmux (
		.port_sel  (port_sel),
		.porthit   (porthit),
		.a_hi_idx  (a[11:8]),
		.iorq_n    (iorq_n),
		.rd_n      (rd_n),
		.keys      (keys),
		.tape_in   (tape_in),
		.kjoy      (kjoy),
		.mouse     (mouse),
		.shadow_en (shadow_en),
		.rom_we    (rom_we),
		.font_we   (font_we),
		.set_nmi   (set_nmi),
		.p7ffd_raw (p7ffd_raw),
		.peff7_raw (peff7_raw),
		.dout      (dout),
		.dataout   (dataout)
	);

	// read pulse lands while the Z80 still holds the read, so dout is on the bus
	a_rd_in_cycle: assert property (@(posedge zclk) disable iff (!rst_n)
		port_rd |-> (!iorq_n && !rd_n));

endmodule

//--- rtl/port_read_mux.sv
// Z80 read data select and data bus drive enable

`timescale 1ns/1ps

module port_read_mux
	import zx_port_pkg::*;
(
	input  port_sel_e  port_sel,
	input  logic       porthit,
	input  logic [3:0] a_hi_idx,
	input  logic       iorq_n,
	input  logic       rd_n,
	input  logic [4:0] keys,
	input  logic       tape_in,
	input  logic [4:0] kjoy,
	input  logic [7:0] mouse,
	input  logic       shadow_en,
	input  logic       rom_we,
	input  logic       font_we,
	input  logic       set_nmi,
	input  logic [7:0] p7ffd_raw,
	input  logic [7:0] peff7_raw,
	output logic [7:0] dout,
	output logic       dataout
);

	logic [7:0] be_byte;

	// xxBE readback by a[11:8]
	always_comb
	begin
		if (a_hi_idx == BE_IDX_7FFD)
			be_byte = p7ffd_raw;
		else if (a_hi_idx == BE_IDX_EFF7)
			be_byte = peff7_raw;
		else
			be_byte = IDLE_READ;
	end

	always_comb
	begin
		case (port_sel)
			SEL_FE:    dout = {1'b1, tape_in, 1'b0, keys};
			SEL_KJOY:  dout = {3'b000, kjoy};
			SEL_MOUSE: dout = mouse;
			SEL_BF:    dout = {4'b0000, set_nmi, font_we, rom_we, shadow_en};
			SEL_BE:    dout = be_byte;
			default:   dout = IDLE_READ; // write-only or unmapped
		endcase
	end

	assign dataout = porthit & ~iorq_n & ~rd_n;

endmodule

//--- rtl/ext_config.sv
// xxBF control bits, extended config bytes,
// border register and NMI clear strobe

`timescale 1ns/1ps

module ext_config
	import zx_port_pkg::*;
	import zx_cfg_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  logic       port_wr,
	input  port_sel_e  port_sel,
	input  logic [7:0] a_hi,
	input  logic [7:0] din,
	input  logic       dos,
	output logic       shadow,
	output logic       shadow_en,
	output logic       rom_we,
	output logic       font_we,
	output logic       set_nmi,
	output logic       clr_nmi,
	output logic [7:0] border,
	output logic [7:0] romconfig,
	output logic [7:0] vpage,
	output logic [7:0] page00,
	output logic [7:0] page01,
	output logic [7:0] page10,
	output logic [7:0] page11,
	output logic [7:0] vconfig,
	output logic [7:0] cpuconfig
);

	logic     bf_wr, fe_wr;
	ext_reg_e reg_idx;

	assign bf_wr   = port_wr && (port_sel == SEL_BF);
	assign fe_wr   = port_wr && (port_sel == SEL_FE);
	assign reg_idx = ext_reg_e'(a_hi);

	// control bits from the low nibble
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			shadow_en <= 1'b0;
			rom_we    <= 1'b0;
			font_we   <= 1'b0;
			set_nmi   <= 1'b0;
		end
		else if (bf_wr)
		begin
			shadow_en <= din[CFG_SHADOW_BIT];
			rom_we    <= din[CFG_ROMRW_BIT];
			font_we   <= din[CFG_FNTW_BIT];
			set_nmi   <= din[CFG_NMI_BIT];
		end
	end

	//////////////////////////////////////////////////
	// extended config bytes, indexed by a[15:8]
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			romconfig <= EXT_RESET;
			vpage     <= EXT_RESET;
			page00    <= EXT_RESET;
			page01    <= EXT_RESET;
			page10    <= EXT_RESET;
			page11    <= EXT_RESET;
			vconfig   <= EXT_RESET;
			cpuconfig <= EXT_RESET;
		end
		else if (bf_wr)
		begin
			case (reg_idx)
				ROMCONFIG: romconfig <= din;
				VPAGE:     vpage     <= din;
				PAGE00:    page00    <= din;
				PAGE01:    page01    <= din;
				PAGE10:    page10    <= din;
				PAGE11:    page11    <= din;
				VCONFIG:   vconfig   <= din;
				CPUCONFIG: cpuconfig <= din;
				default:   ; // unmapped index, border handled below
			endcase
		end
	end

	// FE gives the 3-bit spectrum colour, XBORDER the full byte
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			border <= EXT_RESET;
		else if (fe_wr)
			border <= {din[1], 1'b0, din[2], 1'b0, din[0], 3'b000};
		else if (bf_wr && (reg_idx == XBORDER))
			border <= din;
	end

	assign clr_nmi = port_wr && (port_sel == SEL_BE); // nmi handler exit
	assign shadow  = dos | shadow_en;

endmodule

//--- rtl/mem_pager.sv
// 7FFD and EFF7 paging registers, 7FFD lock,
// boot rom bit and 1M paging outputs

`timescale 1ns/1ps

module mem_pager
	import zx_port_pkg::*;
	import zx_cfg_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  logic       port_wr,
	input  port_sel_e  port_sel,
	input  logic [7:0] din,
	input  logic [1:0] rom_sel,
	output logic [7:0] p7ffd,
	output logic [7:0] peff7,
	output logic [7:0] p7ffd_raw,
	output logic [7:0] peff7_raw,
	output logic [5:0] pent1m_page,
	output logic       pent1m_rom,
	output logic       pent1m_1m_on,
	output logic       pent1m_ram0_0
);

	logic [7:0] p7ffd_q, peff7_q;
	logic       rom_bit;
	logic [1:0] rst_sync; // high while reset settles
	logic       block1m, lock, wr_7ffd, wr_eff7;

	assign block1m = peff7_q[PEFF7_BLOCK1M_BIT];
	assign lock    = p7ffd_q[P7FFD_LOCK_BIT] & block1m;
	assign wr_7ffd = port_wr && (port_sel == SEL_7FFD) && !lock;
	assign wr_eff7 = port_wr && (port_sel == SEL_EFF7);

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_q  <= 8'h00;
			peff7_q  <= 8'h00;
			rst_sync <= 2'b11;
		end
		else
		begin
			rst_sync <= {rst_sync[0], 1'b0};
			if (wr_7ffd)
				p7ffd_q <= din;
			if (wr_eff7)
				peff7_q <= din;
		end
	end

	// boot rom from rom_sel[0] until reset is synced
	always_ff @(posedge zclk)
	begin
		if (rst_sync[1])
			rom_bit <= rom_sel[0];
		else if (wr_7ffd)
			rom_bit <= din[4];
	end

	//////////////////////////////////////////////////
	// paging outputs
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_q[7:5]), rom_bit, p7ffd_q[3:0]};
	assign peff7 = block1m ? {peff7_q[7], 1'b0, peff7_q[5:4], 3'b000, peff7_q[0]}
		: peff7_q;

	assign p7ffd_raw     = p7ffd_q;
	assign peff7_raw     = peff7_q;
	assign pent1m_page   = {p7ffd_q[7:5], p7ffd_q[2:0]}; // full 1M page
	assign pent1m_rom    = p7ffd_q[4];
	assign pent1m_1m_on  = ~block1m;
	assign pent1m_ram0_0 = peff7_q[3];

	// a locked 7FFD keeps its whole value, rom bit included, through the write
	a_7ffd_lock: assert property (@(posedge zclk) disable iff (!rst_n)
		(port_wr && (port_sel == SEL_7FFD) && p7ffd_raw[P7FFD_LOCK_BIT]
			&& peff7_raw[PEFF7_BLOCK1M_BIT]) |=> $stable(p7ffd));

endmodule

//--- rtl/port_decoder.sv
// low address byte decode into a port selection and porthit

`timescale 1ns/1ps

module port_decoder
	import zx_port_pkg::*;
(
	input  logic [15:0] a,
	input  logic        shadow,
	output port_sel_e   port_sel,
	output logic        porthit
);

	logic [7:0] loa;

	assign loa = a[7:0];

	always_comb
	begin
		port_sel = SEL_NONE;
		case (loa)
			PORT_FE, PORT_F6:
				port_sel = SEL_FE;
			PORT_FD:
				if (!a[15])
					port_sel = SEL_7FFD;
			// EFF7 only, and hidden while in shadow mode
			PORT_F7:
				if (a[8] && !a[12] && !shadow)
					port_sel = SEL_EFF7;
			PORT_BF:
				port_sel = SEL_BF;
			PORT_BE:
				port_sel = SEL_BE;
			PORT_KJOY:
				if (!shadow) // 1F is a disk port under dos
					port_sel = SEL_KJOY;
			PORT_MOUSE:
				port_sel = SEL_MOUSE;
			default:
				port_sel = SEL_NONE;
		endcase
	end

	assign porthit = (port_sel != SEL_NONE);

endmodule

//--- rtl/z80_io_strobe.sv
// Z80 I/O cycle edge detect, one-cycle read and write pulses

`timescale 1ns/1ps

module z80_io_strobe (
	input  logic zclk,
	input  logic rst_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic port_wr,
	output logic port_rd
);

	logic wr_act, rd_act;
	logic wr_act_q, rd_act_q; // level seen at previous edge

	assign wr_act = ~(iorq_n | wr_n);
	assign rd_act = ~(iorq_n | rd_n);

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_act_q <= 1'b0;
			rd_act_q <= 1'b0;
			port_wr  <= 1'b0;
			port_rd  <= 1'b0;
		end
		else
		begin
			wr_act_q <= wr_act;
			rd_act_q <= rd_act;
			port_wr  <= wr_act & ~wr_act_q; // rising edge of activity
			port_rd  <= rd_act & ~rd_act_q;
		end
	end

	//////////////////////////////////////////////////
	// a cycle is either read or write, never both
	a_wr_rd_excl: assert property (@(posedge zclk) disable iff (!rst_n)
		!(port_wr && port_rd));

	// no back-to-back pulses, the Z80 holds every cycle for several clocks
	a_pulse_gap: assert property (@(posedge zclk) disable iff (!rst_n)
		(port_wr || port_rd) |=> !(port_wr || port_rd));

endmodule

//--- rtl/zx_cfg_pkg.sv
// extended config register indices, reset value
// and bit positions of the control registers

package zx_cfg_pkg;

	// high address byte of a xxBF write picks the byte
	typedef enum logic [7:0] {
		XBORDER   = 8'h00,
		ROMCONFIG = 8'h02,
		VPAGE     = 8'h03,
		PAGE00    = 8'h04,
		PAGE01    = 8'h05,
		PAGE10    = 8'h06,
		PAGE11    = 8'h07,
		VCONFIG   = 8'h08,
		CPUCONFIG = 8'h10
	} ext_reg_e;

	// xxBF control byte
	localparam int CFG_SHADOW_BIT = 0;
	localparam int CFG_ROMRW_BIT  = 1;
	localparam int CFG_FNTW_BIT   = 2;
	localparam int CFG_NMI_BIT    = 3;

	// paging bits
	localparam int P7FFD_LOCK_BIT    = 5; // 48k lock
	localparam int PEFF7_BLOCK1M_BIT = 2; // 1M mode off

	localparam logic [7:0] EXT_RESET = 8'h00;

endpackage

//--- rtl/zx_port_pkg.sv
// port address map, decoded port selections
// and Z80 bus read constants

package zx_port_pkg;

	// low address byte of each kept port
	localparam logic [7:0] PORT_FE    = 8'hFE;
	localparam logic [7:0] PORT_F6    = 8'hF6; // border alias
	localparam logic [7:0] PORT_FD    = 8'hFD; // 7FFD paging
	localparam logic [7:0] PORT_F7    = 8'hF7; // EFF7 paging
	localparam logic [7:0] PORT_BF    = 8'hBF;
	localparam logic [7:0] PORT_BE    = 8'hBE;
	localparam logic [7:0] PORT_KJOY  = 8'h1F;
	localparam logic [7:0] PORT_MOUSE = 8'hDF;

	// one decoded access at a time
	typedef enum logic [3:0] {
		SEL_NONE,
		SEL_FE,
		SEL_7FFD,
		SEL_EFF7,
		SEL_BF,
		SEL_BE,
		SEL_KJOY,
		SEL_MOUSE
	} port_sel_e;

	// a[11:8] index for xxBE readback
	localparam logic [3:0] BE_IDX_7FFD = 4'hA;
	localparam logic [3:0] BE_IDX_EFF7 = 4'hB;

	localparam logic [7:0] IDLE_READ = 8'hFF; // pulled-up bus

endpackage
